/* logic/cp_pkg.sv */
`default_nettype none

package cp_pkg;

	// field widths
	typedef logic [7:0]  byte_t;
	typedef logic [47:0] mac_addr_t;
	typedef logic [15:0] duration_t;
	typedef logic [7:0]  buf_addr_t;
	typedef logic [3:0]  rate_t;
	typedef logic [1:0]  format_t;

	// one byte per valid cycle
	typedef struct packed {
		logic  valid;
		byte_t data;
	} byte_strm_t;

	// byte wide buffer write port
	typedef struct packed {
		logic      en;
		logic      wen;
		buf_addr_t addr;
		byte_t     data;
	} buf_wr_t;

	// result word back to the rx handler
	typedef struct packed {
		logic        respond;
		logic        is_cts;
		logic [5:0]  rsvd;
		byte_t       frame_len;
		logic [15:0] ra_low;
	} rx_res_t;

	typedef enum logic [1:0] {
		st_idle,
		st_collect,
		st_stream,
		st_report
	} builder_state_t;

	// first frame control byte of the control frames
	localparam byte_t FC_RTS = 8'hB4;
	localparam byte_t FC_CTS = 8'hC4;
	localparam byte_t FC_ACK = 8'hD4;

	// type bits [3:2] of a data frame
	localparam logic [1:0] FC_TYPE_DATA = 2'b10;

	// rx header byte offsets
	localparam buf_addr_t HDR_DUR_LO = 8'd2;
	localparam buf_addr_t HDR_DUR_HI = 8'd3;
	localparam buf_addr_t HDR_ADDR2  = 8'd10;

	// response mpdu without fcs, frame length with fcs
	localparam int    RESP_MPDU_LEN  = 10;
	localparam byte_t RESP_FRAME_LEN = 8'd14;

	// transmit descriptor layout
	localparam int        DESC_LEN      = 12;
	localparam buf_addr_t DESC_FMT      = 8'd0;
	localparam buf_addr_t DESC_RATE_LEN = 8'd2;
	localparam buf_addr_t DESC_LEN_HI   = 8'd3;

endpackage

`default_nettype wire

/* logic/rx_hdr_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_hdr_reader
	import cp_pkg::*;
#(
	parameter int RX_HDR_LEN = 16
) (
	input  wire        clk,
	input  wire        arst_n,
	input  wire        cp_en,
	input  wire        process_rx_frame,
	input  wire        frame_done,
	output logic       rx_info_en,
	output buf_addr_t  rx_info_addr,
	input  wire byte_t rx_info_data,
	output byte_strm_t hdr_strm
);

	localparam buf_addr_t LAST_ADDR = buf_addr_t'(RX_HDR_LEN - 1);

	logic  busy;
	logic  accept;
	logic  rd_vld;
	logic  strm_vld;
	byte_t strm_data;

	// one frame in flight, strobes while busy are dropped
	assign accept = process_rx_frame && !busy;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
		end else if (!cp_en) begin
			busy <= 1'b0;
		end else if (accept) begin
			busy <= 1'b1;
		end else if (frame_done) begin
			busy <= 1'b0;
		end
	end

	// address sequencer, the address doubles as the read counter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_info_en   <= 1'b0;
			rx_info_addr <= '0;
		end else if (!cp_en) begin
			rx_info_en   <= 1'b0;
			rx_info_addr <= '0;
		end else if (accept) begin
			rx_info_en   <= 1'b1;
			rx_info_addr <= '0;
		end else if (rx_info_en) begin
			if (rx_info_addr == LAST_ADDR) begin
				rx_info_en   <= 1'b0;
				rx_info_addr <= '0;
			end else begin
				rx_info_addr <= rx_info_addr + 8'd1;
			end
		end
	end

	// buffer data shows up one cycle after its address
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_vld   <= 1'b0;
			strm_vld <= 1'b0;
		end else if (!cp_en) begin
			rd_vld   <= 1'b0;
			strm_vld <= 1'b0;
		end else begin
			rd_vld   <= rx_info_en;
			strm_vld <= rd_vld;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_vld) begin
			strm_data <= rx_info_data;
		end
	end

	assign hdr_strm = '{valid: strm_vld, data: strm_data};

	a_addr_range: assert property (@(posedge clk) disable iff (!arst_n)
		rx_info_en |-> rx_info_addr <= LAST_ADDR);

endmodule

`default_nettype wire

/* logic/ctrl_resp_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_resp_builder
	import cp_pkg::*;
#(
	parameter int RX_HDR_LEN = 16
) (
	input  wire            clk,
	input  wire            arst_n,
	input  wire            cp_en,
	input  wire byte_strm_t hdr_strm,
	input  wire duration_t sifs_time,
	output byte_strm_t     mpdu_strm,
	output logic           res_val,
	output rx_res_t        res
);

	localparam buf_addr_t  LAST_BYTE = buf_addr_t'(RX_HDR_LEN - 1);
	localparam logic [3:0] LAST_MPDU = 4'(RESP_MPDU_LEN - 1);

	builder_state_t state;
	buf_addr_t      hdr_cnt;
	logic [3:0]     out_cnt;
	byte_t          rx_fc;
	duration_t      rx_dur;
	mac_addr_t      addr2;
	logic           resp_cts;
	logic           resp_ack;
	logic           respond;
	logic           is_rts;
	logic           is_data;
	duration_t      resp_dur;
	byte_t          mpdu_byte;

	// addr2 must be inside the header that is read
	if (RX_HDR_LEN < 16) begin : g_len_check
		$error("RX_HDR_LEN below 16 leaves addr2 unread");
	end

	assign is_rts  = (rx_fc == FC_RTS);
	assign is_data = (rx_fc[3:2] == FC_TYPE_DATA);
	assign respond = resp_cts || resp_ack;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= st_idle;
			hdr_cnt  <= '0;
			out_cnt  <= '0;
			resp_cts <= 1'b0;
			resp_ack <= 1'b0;
		end else if (!cp_en) begin
			state    <= st_idle;
			hdr_cnt  <= '0;
			out_cnt  <= '0;
			resp_cts <= 1'b0;
			resp_ack <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (hdr_strm.valid) begin
						hdr_cnt <= 8'd1;
						state   <= st_collect;
					end
				end
				st_collect: begin
					if (hdr_strm.valid) begin
						hdr_cnt <= hdr_cnt + 8'd1;
						// decision on the last header byte
						if (hdr_cnt == LAST_BYTE) begin
							resp_cts <= is_rts;
							resp_ack <= is_data;
							out_cnt  <= '0;
							state    <= (is_rts || is_data) ? st_stream : st_report;
						end
					end
				end
				st_stream: begin
					out_cnt <= out_cnt + 4'd1;
					if (out_cnt == LAST_MPDU) begin
						state <= st_report;
					end
				end
				st_report: state <= st_idle;
				default:   state <= st_idle;
			endcase
		end
	end

	// header fields with a little endian duration
	always_ff @(posedge clk) begin
		if (state == st_idle && hdr_strm.valid) begin
			rx_fc <= hdr_strm.data;
		end
		if (state == st_collect && hdr_strm.valid) begin
			case (hdr_cnt)
				HDR_DUR_LO:        rx_dur[7:0]   <= hdr_strm.data;
				HDR_DUR_HI:        rx_dur[15:8]  <= hdr_strm.data;
				HDR_ADDR2:         addr2[7:0]    <= hdr_strm.data;
				HDR_ADDR2 + 8'd1:  addr2[15:8]   <= hdr_strm.data;
				HDR_ADDR2 + 8'd2:  addr2[23:16]  <= hdr_strm.data;
				HDR_ADDR2 + 8'd3:  addr2[31:24]  <= hdr_strm.data;
				HDR_ADDR2 + 8'd4:  addr2[39:32]  <= hdr_strm.data;
				HDR_ADDR2 + 8'd5:  addr2[47:40]  <= hdr_strm.data;
				default: ;
			endcase
		end
	end

	// cts duration saturates at zero and ack carries zero
	assign resp_dur = (resp_cts && rx_dur > sifs_time) ? rx_dur - sifs_time : '0;

	always_comb begin
		case (out_cnt)
			4'd0:    mpdu_byte = resp_cts ? FC_CTS : FC_ACK;
			4'd1:    mpdu_byte = 8'h00;
			4'd2:    mpdu_byte = resp_dur[7:0];
			4'd3:    mpdu_byte = resp_dur[15:8];
			// ra is the received addr2 with byte 10 first
			4'd4:    mpdu_byte = addr2[7:0];
			4'd5:    mpdu_byte = addr2[15:8];
			4'd6:    mpdu_byte = addr2[23:16];
			4'd7:    mpdu_byte = addr2[31:24];
			4'd8:    mpdu_byte = addr2[39:32];
			4'd9:    mpdu_byte = addr2[47:40];
			default: mpdu_byte = '0;
		endcase
	end

	assign mpdu_strm = '{valid: state == st_stream, data: mpdu_byte};
	assign res_val   = (state == st_report);
	assign res = '{
		respond:   respond,
		is_cts:    resp_cts,
		rsvd:      '0,
		frame_len: respond ? RESP_FRAME_LEN : '0,
		ra_low:    respond ? addr2[15:0] : '0
	};

	// a response runs ten stream cycles and then reports
	a_mpdu_run: assert property (@(posedge clk) disable iff (!arst_n || !cp_en)
		$rose(mpdu_strm.valid) |-> mpdu_strm.valid [*RESP_MPDU_LEN] ##1 res_val);

endmodule

`default_nettype wire

/* logic/tx_frame_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_frame_writer
	import cp_pkg::*;
#(
	parameter int MPDU_BASE = 56
) (
	input  wire             clk,
	input  wire             arst_n,
	input  wire             cp_en,
	input  wire byte_strm_t mpdu_strm,
	input  wire             res_val,
	input  wire rx_res_t    res,
	input  wire rate_t      resp_rate,
	input  wire format_t    txvec_format,
	output buf_wr_t         tx_info,
	output logic            rx_res_en,
	output rx_res_t         rx_res
);

	localparam buf_addr_t MPDU_ADDR = buf_addr_t'(MPDU_BASE);
	localparam buf_addr_t LAST_DESC = buf_addr_t'(DESC_LEN - 1);

	buf_addr_t mpdu_cnt;
	buf_addr_t desc_cnt;
	logic      desc_act;
	logic      desc_done;
	rx_res_t   res_q;
	byte_t     desc_byte;

	// mpdu byte index rewinds once the frame result arrives
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mpdu_cnt <= '0;
		end else if (!cp_en) begin
			mpdu_cnt <= '0;
		end else if (mpdu_strm.valid) begin
			mpdu_cnt <= mpdu_cnt + 8'd1;
		end else if (res_val) begin
			mpdu_cnt <= '0;
		end
	end

	// descriptor pass only for frames that get a response
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			desc_act  <= 1'b0;
			desc_cnt  <= '0;
			desc_done <= 1'b0;
		end else if (!cp_en) begin
			desc_act  <= 1'b0;
			desc_cnt  <= '0;
			desc_done <= 1'b0;
		end else begin
			desc_done <= 1'b0;
			if (res_val && res.respond) begin
				desc_act <= 1'b1;
				desc_cnt <= '0;
			end else if (desc_act) begin
				desc_cnt <= desc_cnt + 8'd1;
				if (desc_cnt == LAST_DESC) begin
					desc_act  <= 1'b0;
					desc_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (res_val) begin
			res_q <= res;
		end
	end

	// format, legacy rate and frame length with the rest zero
	always_comb begin
		case (desc_cnt)
			DESC_FMT:      desc_byte = {6'd0, txvec_format};
			DESC_RATE_LEN: desc_byte = {res_q.frame_len[3:0], resp_rate};
			DESC_LEN_HI:   desc_byte = {4'd0, res_q.frame_len[7:4]};
			default:       desc_byte = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_info <= '0;
		end else if (!cp_en) begin
			tx_info <= '0;
		end else if (mpdu_strm.valid) begin
			tx_info <= '{en: 1'b1, wen: 1'b1, addr: MPDU_ADDR + mpdu_cnt,
				data: mpdu_strm.data};
		end else if (desc_act) begin
			tx_info <= '{en: 1'b1, wen: 1'b1, addr: desc_cnt, data: desc_byte};
		end else begin
			tx_info <= '0;
		end
	end

	// result to the rx handler is zero between strobes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_res_en <= 1'b0;
			rx_res    <= '0;
		end else if (!cp_en) begin
			rx_res_en <= 1'b0;
			rx_res    <= '0;
		end else if (desc_done) begin
			rx_res_en <= 1'b1;
			rx_res    <= res_q;
		end else if (res_val && !res.respond) begin
			rx_res_en <= 1'b1;
			rx_res    <= res;
		end else begin
			rx_res_en <= 1'b0;
			rx_res    <= '0;
		end
	end

	// every write lands in the descriptor or in the mpdu area
	a_wen_en: assert property (@(posedge clk) disable iff (!arst_n)
		tx_info.wen |-> tx_info.en && (tx_info.addr <= LAST_DESC ||
			buf_addr_t'(tx_info.addr - MPDU_ADDR) < RESP_MPDU_LEN));

	a_res_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		rx_res_en |=> !rx_res_en);

endmodule

`default_nettype wire

/* logic/ctrl_frame_proc.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_frame_proc
	import cp_pkg::*;
#(
	parameter int RX_HDR_LEN = 16,
	parameter int MPDU_BASE  = 56
) (
	input  wire            clk,
	input  wire            arst_n,
	input  wire            cp_en,
	input  wire            process_rx_frame,
	input  wire duration_t sifs_time,
	input  wire rate_t     resp_rate,
	input  wire format_t   txvec_format,
	output logic           rx_info_en,
	output buf_addr_t      rx_info_addr,
	input  wire byte_t     rx_info_data,
	output buf_wr_t        tx_info,
	output rx_res_t        rx_res,
	output logic           rx_res_en
);

	byte_strm_t hdr_strm;
	byte_strm_t mpdu_strm;
	logic       res_val;
	rx_res_t    res;

	// result strobe also releases the reader
	rx_hdr_reader #(
		.RX_HDR_LEN(RX_HDR_LEN)
	) u_reader (
		.clk             (clk),
		.arst_n          (arst_n),
		.cp_en           (cp_en),
		.process_rx_frame(process_rx_frame),
		.frame_done      (rx_res_en),
		.rx_info_en      (rx_info_en),
		.rx_info_addr    (rx_info_addr),
		.rx_info_data    (rx_info_data),
		.hdr_strm        (hdr_strm)
	);

	ctrl_resp_builder #(
		.RX_HDR_LEN(RX_HDR_LEN)
	) u_builder (
		.clk      (clk),
		.arst_n   (arst_n),
		.cp_en    (cp_en),
		.hdr_strm (hdr_strm),
		.sifs_time(sifs_time),
		.mpdu_strm(mpdu_strm),
		.res_val  (res_val),
		.res      (res)
	);

	tx_frame_writer #(
		.MPDU_BASE(MPDU_BASE)
	) u_writer (
		.clk         (clk),
		.arst_n      (arst_n),
		.cp_en       (cp_en),
		.mpdu_strm   (mpdu_strm),
		.res_val     (res_val),
		.res         (res),
		.resp_rate   (resp_rate),
		.txvec_format(txvec_format),
		.tx_info     (tx_info),
		.rx_res_en   (rx_res_en),
		.rx_res      (rx_res)
	);

endmodule

`default_nettype wire

/* verification/tb_ctrl_frame_proc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_frame_proc
	import cp_pkg::*;
();

	localparam int HDR_LEN        = 16;
	localparam int MPDU_BASE      = 56;
	localparam int HDR_BITS       = HDR_LEN * 8;
	localparam int FRAME_COUNT    = 26;
	localparam int TIMEOUT_CYCLES = 60 * FRAME_COUNT + 200;

	logic      clk = 1'b0;
	logic      arst_n;
	logic      cp_en;
	logic      process_rx_frame;
	duration_t sifs_time;
	rate_t     resp_rate;
	format_t   txvec_format;
	logic      rx_info_en;
	buf_addr_t rx_info_addr;
	byte_t     rx_info_data;
	buf_wr_t   tx_info;
	rx_res_t   rx_res;
	logic      rx_res_en;

	byte_t       rx_mem [256];
	byte_t       tx_mem [256];
	int          wr_count;
	integer      seed;
	int          err_count;
	int          check_count;
	int          test_count;
	int          res_count;
	int          base_count;
	int          cycle_count;
	logic        exp_pending;
	rx_res_t     exp_res;
	logic [79:0] exp_mpdu;
	logic [95:0] exp_desc;

	always #10 clk = ~clk;

	ctrl_frame_proc #(
		.RX_HDR_LEN(HDR_LEN),
		.MPDU_BASE (MPDU_BASE)
	) dut (
		.clk             (clk),
		.arst_n          (arst_n),
		.cp_en           (cp_en),
		.process_rx_frame(process_rx_frame),
		.sifs_time       (sifs_time),
		.resp_rate       (resp_rate),
		.txvec_format    (txvec_format),
		.rx_info_en      (rx_info_en),
		.rx_info_addr    (rx_info_addr),
		.rx_info_data    (rx_info_data),
		.tx_info         (tx_info),
		.rx_res          (rx_res),
		.rx_res_en       (rx_res_en)
	);

	// rx buffer with one cycle read latency
	always @(posedge clk) begin
		if (rx_info_en) begin
			rx_info_data <= rx_mem[rx_info_addr];
		end
	end

	// tx buffer accepts every write
	always @(posedge clk) begin
		if (tx_info.en && tx_info.wen) begin
			tx_mem[tx_info.addr] <= tx_info.data;
			wr_count <= wr_count + 1;
		end
	end

	function automatic byte_t tx_fill(input logic [7:0] a);
		return a ^ 8'hA5;
	endfunction

	// response rules of the control frame path
	function automatic rx_res_t expected_response(
		input  logic [HDR_BITS-1:0] hdr,
		input  duration_t           sifs,
		input  rate_t               rate,
		input  format_t             fmt,
		output logic [79:0]         mpdu,
		output logic [95:0]         desc
	);
		byte_t     fc;
		duration_t dur;
		duration_t out_dur;
		rx_res_t   r;
		fc      = hdr[7:0];
		dur     = hdr[31:16];
		out_dur = '0;
		r       = '0;
		mpdu    = '0;
		desc    = '0;
		if (fc == FC_RTS) begin
			r.respond  = 1'b1;
			r.is_cts   = 1'b1;
			out_dur    = (dur > sifs) ? dur - sifs : 16'd0;
			mpdu[7:0]  = FC_CTS;
		end else if (fc[3:2] == 2'b10) begin
			r.respond  = 1'b1;
			mpdu[7:0]  = FC_ACK;
		end
		if (r.respond) begin
			mpdu[31:16]  = out_dur;
			// ra is addr2 from header bytes 10 to 15
			mpdu[79:32]  = hdr[127:80];
			r.frame_len  = 8'd14;
			r.ra_low     = hdr[95:80];
			desc[7:0]    = {6'd0, fmt};
			desc[23:16]  = {r.frame_len[3:0], rate};
			desc[31:24]  = {4'd0, r.frame_len[7:4]};
		end
		return r;
	endfunction

	function automatic logic [HDR_BITS-1:0] make_header(
		input byte_t     fc,
		input duration_t dur,
		input byte_t     base
	);
		logic [HDR_BITS-1:0] h;
		h        = '0;
		h[7:0]   = fc;
		h[31:16] = dur;
		for (int i = 4; i < HDR_LEN; i++) begin
			h[8*i +: 8] = base + byte_t'(i);
		end
		return h;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			err_count++;
		end
	endtask

	// compare each result with the reference
	always @(negedge clk) begin
		if (rx_res_en) begin
			res_count++;
			if (!exp_pending) begin
				$display("error at %0t ns: rx_res_en pulsed with no frame pending", $time);
				err_count++;
			end else begin
				check("rx_res", rx_res, exp_res);
				for (int i = 0; i < DESC_LEN; i++) begin
					check($sformatf("tx_mem[%0d]", i), tx_mem[i],
						exp_res.respond ? exp_desc[8*i +: 8] : tx_fill(i));
				end
				for (int i = 0; i < RESP_MPDU_LEN; i++) begin
					check($sformatf("tx_mem[%0d]", MPDU_BASE + i), tx_mem[MPDU_BASE + i],
						exp_res.respond ? exp_mpdu[8*i +: 8] : tx_fill(MPDU_BASE + i));
				end
				check("tx write count", wr_count, exp_res.respond ? DESC_LEN + RESP_MPDU_LEN : 0);
			end
			exp_pending = 1'b0;
		end else begin
			check("rx_res between strobes", rx_res, '0);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("timeout: run still busy after %0d cycles", cycle_count);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic start_frame(input logic [HDR_BITS-1:0] hdr, input logic expect_result);
		@(posedge clk);
		#1;
		for (int i = 0; i < HDR_LEN; i++) begin
			rx_mem[i] = hdr[8*i +: 8];
		end
		for (int i = 0; i < 256; i++) begin
			tx_mem[i] = tx_fill(i);
		end
		wr_count    = 0;
		exp_res     = expected_response(hdr, sifs_time, resp_rate, txvec_format,
			exp_mpdu, exp_desc);
		exp_pending = expect_result;
		base_count  = res_count;
		process_rx_frame = 1'b1;
		@(posedge clk);
		#1;
		process_rx_frame = 1'b0;
	endtask

	task automatic wait_result();
		while (res_count == base_count) begin
			@(posedge clk);
		end
		#1;
	endtask

	// mixed rts, data and other frames
	task automatic random_header(output logic [HDR_BITS-1:0] hdr);
		int    kind;
		byte_t r;
		for (int i = 0; i < HDR_LEN; i++) begin
			hdr[8*i +: 8] = $random(seed);
		end
		kind = {$random(seed)} % 3;
		r    = $random(seed);
		case (kind)
			0:       hdr[7:0] = FC_RTS;
			1:       hdr[7:0] = {r[7:4], 2'b10, r[1:0]};
			default: hdr[7:0] = r[0] ? {r[7:4], 2'b00, r[1:0]} : FC_ACK;
		endcase
		// durations near sifs so that some saturate
		hdr[31:25]   = '0;
		sifs_time    = {$random(seed)} % 512;
		resp_rate    = $random(seed);
		txvec_format = $random(seed);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_count++;
		$display("test %0d %s: %0d errors", test_count, name, err_count - errs_before);
	endtask

	initial begin
		logic [HDR_BITS-1:0] hdr;
		int                  errs;
		seed             = 32'had93_b8e3;
		arst_n           = 1'b0;
		cp_en            = 1'b1;
		process_rx_frame = 1'b0;
		sifs_time        = 16'd16;
		resp_rate        = 4'hB;
		txvec_format     = 2'd1;
		rx_info_data     = '0;
		wr_count         = 0;
		exp_pending      = 1'b0;
		for (int i = 0; i < 256; i++) begin
			rx_mem[i] = {i[3:0], i[7:4]} ^ 8'h3C;
		end
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;

		errs = err_count;
		start_frame(make_header(FC_RTS, 16'h0123, 8'h40), 1'b1);
		wait_result();
		finish_test("rts_to_cts", errs);

		errs = err_count;
		start_frame(make_header(FC_RTS, 16'h000A, 8'h50), 1'b1);
		wait_result();
		finish_test("cts_duration_saturates", errs);

		errs = err_count;
		start_frame(make_header(8'h08, 16'h002C, 8'h60), 1'b1);
		wait_result();
		finish_test("data_to_ack", errs);

		errs = err_count;
		start_frame(make_header(8'h80, 16'h0000, 8'h70), 1'b1);
		wait_result();
		finish_test("mgmt_no_response", errs);

		// second strobe while the header is being read
		errs = err_count;
		start_frame(make_header(FC_RTS, 16'h0200, 8'h90), 1'b1);
		repeat (6) @(posedge clk);
		#1;
		process_rx_frame = 1'b1;
		@(posedge clk);
		#1;
		process_rx_frame = 1'b0;
		wait_result();
		repeat (40) @(posedge clk);
		check("results per frame", res_count - base_count, 1);
		finish_test("busy_strobe_ignored", errs);

		errs = err_count;
		start_frame(make_header(FC_RTS, 16'h0300, 8'hC0), 1'b0);
		repeat (10) @(posedge clk);
		#1;
		cp_en = 1'b0;
		@(posedge clk);
		repeat (10) begin
			@(negedge clk);
			check("rx_info_en", rx_info_en, 1'b0);
			check("tx_info.en", tx_info.en, 1'b0);
			check("tx_info.wen", tx_info.wen, 1'b0);
			check("rx_res_en", rx_res_en, 1'b0);
		end
		@(posedge clk);
		#1;
		cp_en = 1'b1;
		repeat (30) @(posedge clk);
		check("results after abort", res_count - base_count, 0);
		check("tx write count after abort", wr_count, 0);
		finish_test("cp_en_abort", errs);

		errs = err_count;
		for (int k = 0; k < 20; k++) begin
			random_header(hdr);
			start_frame(hdr, 1'b1);
			wait_result();
		end
		finish_test("random_frames", errs);

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
logic/cp_pkg.sv
logic/rx_hdr_reader.sv
logic/ctrl_resp_builder.sv
logic/tx_frame_writer.sv
logic/ctrl_frame_proc.sv
verification/tb_ctrl_frame_proc.sv
